// File: logic/buf_cfg_pkg.sv
`default_nettype none

package buf_cfg_pkg;

	////////////////////////////////////////////////////////////
	// lane geometry
	////////////////////////////////////////////////////////////

	localparam int N_LANES   = 4;
	localparam int DATA_W    = 64;
	localparam int DEPTH     = 64;              // words per slice memory
	localparam int ADDR_W    = $clog2(DEPTH);
	localparam int CNT_W     = ADDR_W + 1;      // must hold DEPTH itself
	localparam int ZERO_LANE = 3;               // lane that zero-fills in layer 1

	typedef logic [DATA_W-1:0] lane_data_t;
	typedef logic [ADDR_W-1:0] lane_addr_t;
	typedef logic [CNT_W-1:0]  depth_t;
	typedef logic [2:0]        layer_t;

	////////////////////////////////////////////////////////////
	// per-layer slice depth
	////////////////////////////////////////////////////////////

	// a depth of 0 marks a layer code that is not in use
	localparam depth_t LAYER_DEPTH [0:7] = '{
		depth_t'(0),
		depth_t'(16),   // layer 1
		depth_t'(24),   // layer 2
		depth_t'(40),   // layer 3
		depth_t'(64),   // layer 4
		depth_t'(0),
		depth_t'(0),
		depth_t'(0)
	};

endpackage

`default_nettype wire

// File: logic/buf_ctrl_pkg.sv
`default_nettype none

package buf_ctrl_pkg;

	// configuration controller
	typedef enum logic [1:0] {
		IDLE,
		CONFIG,   // depth and zero-fill get loaded here
		WORK
	} cfg_state_t;

	// per-lane slice state
	typedef enum logic [1:0] {
		EMPTY,
		FILL,     // taking words from the input stream
		FULL,     // slice held until a read request
		READ
	} lane_state_t;

endpackage

`default_nettype wire

// File: logic/lane_if.sv
`timescale 1ns/100ps
`default_nettype none

interface lane_if;
	import buf_cfg_pkg::*;

	// from the configuration controller
	logic       start_wr;    // one-cycle pulse
	logic       start_rd;    // one-cycle pulse
	depth_t     depth;       // stable for the whole slice
	logic       zero_fill;

	// from the lane
	logic       wr_done;
	logic       rd_valid;
	lane_data_t rd_data;
	logic       rd_last;     // last word of the slice
	logic       rd_done;

	modport feed (
		output start_wr, start_rd, depth, zero_fill
	);

	modport lane (
		input  start_wr, start_rd, depth, zero_fill,
		output wr_done, rd_valid, rd_data, rd_last, rd_done
	);

	modport drain (
		input wr_done, rd_valid, rd_data, rd_last, rd_done
	);

endinterface

`default_nettype wire

// File: logic/slice_ram.sv
`timescale 1ns/100ps
`default_nettype none

module slice_ram (
	input  wire                          clk,
	input  wire                          wr_en,
	input  wire buf_cfg_pkg::lane_addr_t wr_addr,
	input  wire buf_cfg_pkg::lane_data_t wr_data,
	input  wire                          rd_en,
	input  wire buf_cfg_pkg::lane_addr_t rd_addr,
	output buf_cfg_pkg::lane_data_t      rd_data
);
	import buf_cfg_pkg::*;

	lane_data_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read, one cycle latency
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

	a_no_collision: assert property (
		@(posedge clk)
		wr_en && rd_en |-> wr_addr != rd_addr
	) else $error("slice_ram write and read hit the same address");

endmodule

`default_nettype wire

// File: logic/slice_lane.sv
`timescale 1ns/100ps
`default_nettype none

module slice_lane (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          s_tvalid,
	output logic                         s_tready,
	input  wire buf_cfg_pkg::lane_data_t s_tdata,
	lane_if.lane                         lane
);
	import buf_cfg_pkg::*;
	import buf_ctrl_pkg::*;

	lane_state_t state;
	depth_t      wr_cnt;
	depth_t      rd_cnt;
	depth_t      last_idx;
	logic        wr_en;
	logic        wr_last;
	lane_data_t  wr_data;
	logic        rd_en;
	logic        rd_last_addr;
	logic        wr_done_r;
	logic        rd_valid_r;
	logic        rd_last_r;
	lane_data_t  ram_q;

	assign last_idx = lane.depth - 1'b1;

	////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////

	// zero-fill lane never asks for input
	assign s_tready = (state == FILL) && !lane.zero_fill;
	assign wr_en    = (state == FILL) && (lane.zero_fill || s_tvalid);
	assign wr_data  = lane.zero_fill ? '0 : s_tdata;
	assign wr_last  = wr_en && (wr_cnt == last_idx);

	// read side with one address per cycle
	assign rd_en        = (state == READ);
	assign rd_last_addr = rd_en && (rd_cnt == last_idx);

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= EMPTY;
			wr_cnt <= '0;
			rd_cnt <= '0;
		end else begin
			case (state)
				EMPTY: begin
					if (lane.start_wr) begin
						state  <= FILL;
						wr_cnt <= '0;
					end
				end
				FILL: begin
					if (wr_en) begin
						wr_cnt <= wr_cnt + 1'b1;
					end
					if (wr_last) begin
						state <= FULL;
					end
				end
				FULL: begin
					if (lane.start_rd) begin
						state  <= READ;
						rd_cnt <= '0;
					end else if (lane.start_wr) begin   // new slice replaces unread one
						state  <= FILL;
						wr_cnt <= '0;
					end
				end
				READ: begin
					rd_cnt <= rd_cnt + 1'b1;
					if (rd_last_addr) begin
						state <= EMPTY;
					end
				end
				default: state <= EMPTY;
			endcase
		end
	end

	// status lines line up with the ram output
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_done_r  <= 1'b0;
			rd_valid_r <= 1'b0;
			rd_last_r  <= 1'b0;
		end else begin
			wr_done_r  <= wr_last;
			rd_valid_r <= rd_en;
			rd_last_r  <= rd_last_addr;
		end
	end

	assign lane.wr_done  = wr_done_r;
	assign lane.rd_valid = rd_valid_r;
	assign lane.rd_data  = ram_q;
	assign lane.rd_last  = rd_last_r;
	assign lane.rd_done  = rd_valid_r && rd_last_r;

	slice_ram u_ram (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_cnt[ADDR_W-1:0]),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_cnt[ADDR_W-1:0]),
		.rd_data (ram_q)
	);

	// a full slice takes no further writes
	a_no_write_when_full: assert property (
		@(posedge clk) disable iff (rst)
		wr_en |-> wr_cnt < lane.depth
	) else $error("slice_lane write past the end of the slice");

endmodule

`default_nettype wire

// File: logic/buffer_config.sv
`timescale 1ns/100ps
`default_nettype none

module buffer_config (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      start,
	input  wire                      start_read,
	input  wire buf_cfg_pkg::layer_t layer,
	lane_if.feed                     lanes [buf_cfg_pkg::N_LANES]
);
	import buf_cfg_pkg::*;
	import buf_ctrl_pkg::*;

	cfg_state_t         state;
	cfg_state_t         state_next;
	layer_t             layer_r;
	depth_t             depth_r;
	logic [N_LANES-1:0] zero_mask;
	logic               start_wr_r;
	logic               start_rd_r;
	logic               layer_ok;

	assign layer_ok = (LAYER_DEPTH[layer] != '0);   // unused codes map to depth 0

	////////////////////////////////////////////////////////////
	// layer capture FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (start && layer_ok) begin
					state_next = CONFIG;
				end
			end
			CONFIG:  state_next = WORK;
			WORK:    state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			layer_r    <= '0;
			depth_r    <= '0;
			zero_mask  <= '0;
			start_wr_r <= 1'b0;
			start_rd_r <= 1'b0;
		end else begin
			if (state == IDLE && start && layer_ok) begin
				layer_r <= layer;
			end
			if (state == CONFIG) begin
				depth_r   <= LAYER_DEPTH[layer_r];
				zero_mask <= '0;
				if (layer_r == layer_t'(1)) begin
					zero_mask[ZERO_LANE] <= 1'b1;   // layer 1 has one all-zero lane
				end
			end
			start_wr_r <= (state == WORK);      // fires the cycle after WORK
			start_rd_r <= start_read;
		end
	end

	// same control to every lane, zero-fill picked per lane
	for (genvar i = 0; i < N_LANES; i++) begin : g_feed
		assign lanes[i].start_wr  = start_wr_r;
		assign lanes[i].start_rd  = start_rd_r;
		assign lanes[i].depth     = depth_r;
		assign lanes[i].zero_fill = zero_mask[i];
	end

	a_state_legal: assert property (
		@(posedge clk) disable iff (rst)
		state inside {IDLE, CONFIG, WORK}
	) else $error("buffer_config state left its legal encodings");

endmodule

`default_nettype wire

// File: logic/slice_collector.sv
`timescale 1ns/100ps
`default_nettype none

module slice_collector (
	input  wire                              clk,
	input  wire                              rst,
	lane_if.drain                            lanes [buf_cfg_pkg::N_LANES],
	output logic                             slice_wr_done,
	output logic                             slice_rd_done,
	output logic [buf_cfg_pkg::N_LANES-1:0]  en_out,
	output buf_cfg_pkg::lane_data_t          dout [buf_cfg_pkg::N_LANES]
);
	import buf_cfg_pkg::*;

	logic [N_LANES-1:0] wr_done_v;
	logic [N_LANES-1:0] rd_done_v;
	logic [N_LANES-1:0] rd_valid_v;
	lane_data_t         rd_data_v [N_LANES];
	logic [N_LANES-1:0] wr_flag;   // sticky, one bit per lane
	logic [N_LANES-1:0] rd_flag;

	for (genvar i = 0; i < N_LANES; i++) begin : g_tap
		assign wr_done_v[i]  = lanes[i].wr_done;
		assign rd_done_v[i]  = lanes[i].rd_done;
		assign rd_valid_v[i] = lanes[i].rd_valid;
		assign rd_data_v[i]  = lanes[i].rd_data;

		a_done_once: assert property (
			@(posedge clk) disable iff (rst)
			(wr_done_v[i] -> !wr_flag[i]) && (rd_done_v[i] -> !rd_flag[i])
		) else $error("lane %0d reported done twice", i);

		// a slice reads out as one unbroken burst
		a_rd_burst: assert property (
			@(posedge clk) disable iff (rst)
			lanes[i].rd_valid && !lanes[i].rd_last |=> lanes[i].rd_valid
		) else $error("lane %0d read burst broke before its last word", i);
	end

	////////////////////////////////////////////////////////////
	// combined done pulses
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_flag       <= '0;
			rd_flag       <= '0;
			slice_wr_done <= 1'b0;
			slice_rd_done <= 1'b0;
		end else begin
			slice_wr_done <= &wr_flag;
			slice_rd_done <= &rd_flag;
			if (&wr_flag) begin
				wr_flag <= '0;              // all lanes in, rearm
			end else begin
				wr_flag <= wr_flag | wr_done_v;
			end
			if (&rd_flag) begin
				rd_flag <= '0;
			end else begin
				rd_flag <= rd_flag | rd_done_v;
			end
		end
	end

	// output register stage
	always_ff @(posedge clk) begin
		if (rst) begin
			en_out <= '0;
		end else begin
			en_out <= rd_valid_v;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < N_LANES; i++) begin
			dout[i] <= rd_data_v[i];
		end
	end

endmodule

`default_nettype wire

// File: logic/input_buffer_top.sv
`timescale 1ns/100ps
`default_nettype none

module input_buffer_top (
	input  wire                             clk,
	input  wire                             rst,
	input  wire                             start,
	input  wire buf_cfg_pkg::layer_t        layer,
	input  wire                             start_read,
	input  wire [buf_cfg_pkg::N_LANES-1:0]  s_tvalid,
	output wire [buf_cfg_pkg::N_LANES-1:0]  s_tready,
	input  wire buf_cfg_pkg::lane_data_t    s_tdata [buf_cfg_pkg::N_LANES],
	output logic                            slice_wr_done,
	output logic                            slice_rd_done,
	output logic [buf_cfg_pkg::N_LANES-1:0] en_out,
	output buf_cfg_pkg::lane_data_t         dout [buf_cfg_pkg::N_LANES]
);
	import buf_cfg_pkg::*;

	lane_if lanes [N_LANES] ();

	buffer_config u_config (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.start_read (start_read),
		.layer      (layer),
		.lanes      (lanes)
	);

	////////////////////////////////////////////////////////////
	// lanes
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < N_LANES; i++) begin : g_lane
		slice_lane u_lane (
			.clk      (clk),
			.rst      (rst),
			.s_tvalid (s_tvalid[i]),
			.s_tready (s_tready[i]),
			.s_tdata  (s_tdata[i]),
			.lane     (lanes[i])
		);
	end

	slice_collector u_collector (
		.clk           (clk),
		.rst           (rst),
		.lanes         (lanes),
		.slice_wr_done (slice_wr_done),
		.slice_rd_done (slice_rd_done),
		.en_out        (en_out),
		.dout          (dout)
	);

endmodule

`default_nettype wire

// File: testbench/input_buffer_tb.sv
`timescale 1ns/100ps
`default_nettype none

module input_buffer_tb;
	import buf_cfg_pkg::*;

	localparam int ZERO_IDX      = 3;    // all-zero lane of layer 1
	localparam int N_SLICES      = 10;
	localparam int N_FIXED       = 4;    // layers 1..4 in order without stalls
	localparam int RESET_CYCLES  = 3;
	localparam int SETTLE        = 3;
	localparam int RD_LATENCY    = 3;
	localparam int IDLE_WINDOW   = 20;
	localparam int SLICE_OVERHEAD = 16;

	logic               clk;
	logic               rst;
	logic               start;
	logic               start_read;
	layer_t             layer;
	logic [N_LANES-1:0] s_tvalid;
	logic [N_LANES-1:0] s_tready;
	lane_data_t         s_tdata [N_LANES];
	logic               slice_wr_done;
	logic               slice_rd_done;
	logic [N_LANES-1:0] en_out;
	lane_data_t         dout [N_LANES];

	logic [31:0] rng_state = 32'hf15d_83c9;
	lane_data_t  model [N_LANES][$];      // expected read-back per lane
	int          acc_cnt [N_LANES];
	int          en_cnt [N_LANES];
	int          cyc;
	int          wr_pulses;
	int          rd_pulses;
	int          rd_req_cyc;
	int          first_en_cyc;
	int          cur_layer;
	int          cur_depth;
	bit          ready_seen;
	int          checks;
	int          value_errs;
	int          other_errs;
	int          watchdog_cycles;
	layer_t      layer_seq [N_SLICES];
	string       cur_test;

	input_buffer_top input_buffer_top_i (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.layer         (layer),
		.start_read    (start_read),
		.s_tvalid      (s_tvalid),
		.s_tready      (s_tready),
		.s_tdata       (s_tdata),
		.slice_wr_done (slice_wr_done),
		.slice_rd_done (slice_rd_done),
		.en_out        (en_out),
		.dout          (dout)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// words per slice for each layer code with 0 for unused codes
	function automatic int slice_depth(input int lyr);
		case (lyr)
			1:       return 16;
			2:       return 24;
			3:       return 40;
			4:       return 64;
			default: return 0;
		endcase
	endfunction

	task automatic value_error(input string test, input logic [63:0] expected,
			input logic [63:0] actual);
		value_errs++;
		$display("** Error [%s] at %0t: expected %h, actual %h", test, $time, expected, actual);
	endtask

	task automatic other_error(input string msg);
		other_errs++;
		$display("** Error [%s] at %0t: %s", cur_test, $time, msg);
	endtask

	////////////////////////////////////////////////////////////
	// monitor samples between rising edges
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin : monitor
		lane_data_t expected;
		cyc++;
		if (!rst) begin
			if (slice_wr_done === 1'b1) wr_pulses++;
			if (slice_rd_done === 1'b1) rd_pulses++;
			if (start_read) rd_req_cyc = cyc;
			if (|en_out && first_en_cyc < 0) first_en_cyc = cyc;
			if (|s_tready) ready_seen = 1'b1;
			if (cur_layer == 1 && s_tready[ZERO_IDX]) begin
				other_error("lane 3 asked for input in the zero-fill layer");
			end
			for (int i = 0; i < N_LANES; i++) begin
				if (s_tvalid[i] && s_tready[i]) begin   // word taken on next edge
					model[i].push_back(s_tdata[i]);
					acc_cnt[i]++;
					if (acc_cnt[i] > cur_depth) begin
						other_error($sformatf("lane %0d took more words than its depth", i));
					end
				end
				if (en_out[i]) begin
					en_cnt[i]++;
					checks++;
					if (model[i].size() == 0) begin
						other_error($sformatf("lane %0d read out more words than it stored", i));
					end else begin
						expected = model[i].pop_front();
						if (dout[i] !== expected) begin
							value_error($sformatf("%s dout[%0d]", cur_test, i), expected, dout[i]);
						end
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// write one slice and read it back
	////////////////////////////////////////////////////////////

	task automatic run_slice(input int slice_idx, input layer_t lyr, input bit stall);
		int depth;
		int n;
		int exp_acc;
		int wr_before;
		int rd_before;
		depth = slice_depth(lyr);
		cur_test = $sformatf("slice %0d layer %0d", slice_idx, lyr);
		cur_layer = lyr;
		cur_depth = depth;
		for (int i = 0; i < N_LANES; i++) begin
			model[i].delete();
			acc_cnt[i] = 0;
			en_cnt[i] = 0;
		end
		if (lyr == 1) begin
			for (int w = 0; w < depth; w++) begin
				model[ZERO_IDX].push_back(lane_data_t'(0));
			end
		end
		wr_before = wr_pulses;
		rd_before = rd_pulses;
		@(posedge clk);
		start <= 1'b1;
		layer <= lyr;
		@(posedge clk);
		start <= 1'b0;
		n = 0;
		while (wr_pulses == wr_before && n < depth * 4) begin
			for (int i = 0; i < N_LANES; i++) begin
				if (stall) begin
					s_tvalid[i] <= (next_rand() % 4) != 0;   // about one gap in four
				end else begin
					s_tvalid[i] <= 1'b1;
				end
				s_tdata[i] <= {next_rand(), next_rand()};
			end
			@(posedge clk);
			n++;
		end
		s_tvalid <= '0;
		if (wr_pulses == wr_before) other_error("timeout waiting for slice_wr_done");
		@(negedge clk);
		checks++;
		if (s_tready !== '0) value_error({cur_test, " s_tready after fill"}, '0, s_tready);
		repeat (SETTLE) @(posedge clk);
		checks++;
		if (wr_pulses - wr_before != 1) begin
			value_error({cur_test, " slice_wr_done cycles"}, 1, wr_pulses - wr_before);
		end
		for (int i = 0; i < N_LANES; i++) begin
			exp_acc = (lyr == 1 && i == ZERO_IDX) ? 0 : depth;
			checks++;
			if (acc_cnt[i] != exp_acc) begin
				value_error($sformatf("%s words taken lane %0d", cur_test, i), exp_acc, acc_cnt[i]);
			end
		end

		// read-back
		first_en_cyc = -1;
		rd_req_cyc = -1;
		start_read <= 1'b1;
		@(posedge clk);
		start_read <= 1'b0;
		n = 0;
		while (rd_pulses == rd_before && n < depth + 20) begin
			@(posedge clk);
			n++;
		end
		if (rd_pulses == rd_before) other_error("timeout waiting for slice_rd_done");
		repeat (SETTLE) @(posedge clk);
		checks++;
		if (rd_pulses - rd_before != 1) begin
			value_error({cur_test, " slice_rd_done cycles"}, 1, rd_pulses - rd_before);
		end
		// start_read is taken on the edge after it is seen high
		checks++;
		if (first_en_cyc != rd_req_cyc + 1 + RD_LATENCY) begin
			value_error({cur_test, " first en_out cycle"}, rd_req_cyc + 1 + RD_LATENCY,
				first_en_cyc);
		end
		for (int i = 0; i < N_LANES; i++) begin
			checks++;
			if (en_cnt[i] != depth) begin
				value_error($sformatf("%s en_out cycles lane %0d", cur_test, i), depth, en_cnt[i]);
			end
		end
	endtask

	task automatic try_invalid_layer(input layer_t lyr);
		int wr_before;
		int rd_before;
		cur_test = $sformatf("invalid layer %0d", lyr);
		cur_layer = lyr;
		cur_depth = 0;
		wr_before = wr_pulses;
		rd_before = rd_pulses;
		ready_seen = 1'b0;
		@(posedge clk);
		start <= 1'b1;
		layer <= lyr;
		s_tvalid <= '1;
		@(posedge clk);
		start <= 1'b0;
		repeat (IDLE_WINDOW) @(posedge clk);
		s_tvalid <= '0;
		checks++;
		if (ready_seen) other_error("s_tready went high after start with an unused layer");
		checks++;
		if (wr_pulses != wr_before || rd_pulses != rd_before) begin
			other_error("a done pulse appeared after start with an unused layer");
		end
	endtask

	initial begin : main
		int total;
		int d;
		rst <= 1'b1;
		start <= 1'b0;
		start_read <= 1'b0;
		layer <= '0;
		s_tvalid <= '0;
		for (int i = 0; i < N_LANES; i++) begin
			s_tdata[i] <= '0;
		end
		for (int k = 0; k < N_SLICES; k++) begin
			if (k < N_FIXED) begin
				layer_seq[k] = layer_t'(k + 1);
			end else begin
				layer_seq[k] = layer_t'((next_rand() % 4) + 1);
			end
		end
		total = RESET_CYCLES + 8 + 4 * (IDLE_WINDOW + 4);
		for (int k = 0; k < N_SLICES; k++) begin
			d = slice_depth(layer_seq[k]);
			total += d * 4 + d + 20 + SLICE_OVERHEAD;   // write bound plus read bound
		end
		watchdog_cycles = total;

		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		cur_test = "after reset";
		repeat (4) begin
			@(negedge clk);
			checks++;
			if ({s_tready, en_out, slice_wr_done, slice_rd_done} !== '0) begin
				value_error(cur_test, '0, {s_tready, en_out, slice_wr_done, slice_rd_done});
			end
		end

		for (int k = 0; k < N_SLICES; k++) begin
			run_slice(k, layer_seq[k], k >= N_FIXED);
		end
		try_invalid_layer(layer_t'(0));
		try_invalid_layer(layer_t'(5));
		try_invalid_layer(layer_t'(6));
		try_invalid_layer(layer_t'(7));

		$display("checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin : watchdog
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run is stopped", watchdog_cycles);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
logic/buf_cfg_pkg.sv
logic/buf_ctrl_pkg.sv
logic/lane_if.sv
logic/slice_ram.sv
logic/slice_lane.sv
logic/buffer_config.sv
logic/slice_collector.sv
logic/input_buffer_top.sv
testbench/input_buffer_tb.sv
